// ==== hw/snake_params.svh ====
// Grid size, coordinate and length widths, start positions, score wrap and LFSR seeds
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// Playfield in cells
`define SNAKE_GRID_W      124
`define SNAKE_GRID_H      81
`define SNAKE_COORD_BITS  7             // Wide enough for both axes

// Snake length
`define SNAKE_LEN_MAX     16            // Head plus 15 body slots
`define SNAKE_LEN_BITS    5             // Must hold the value 16

// Starting snake, head on the left half of the grid
`define SNAKE_START_X     8
`define SNAKE_START_Y     40
`define SNAKE_START_LEN   6

// Starting fruit, two rows below the head
`define SNAKE_FRUIT_X     8
`define SNAKE_FRUIT_Y     42

// Score counts 0..99 then wraps
`define SNAKE_SCORE_WRAP  99

// Fruit generator seeds, never zero
`define SNAKE_LFSR_SEED_X 7'h1c
`define SNAKE_LFSR_SEED_Y 7'h30

`endif

// ==== hw/snake_pkg.sv ====
// Shared types: grid cell, heading, game state, status word and move enables
`include "snake_params.svh"

package snake_pkg;

    // One grid position, x in the upper half
    typedef struct packed {
        logic [`SNAKE_COORD_BITS-1:0] x;        // Column 0..123
        logic [`SNAKE_COORD_BITS-1:0] y;        // Row 0..80
    } cell_t;

    // Clockwise order, so +1 is a right turn and -1 a left turn
    typedef enum logic [1:0] {
        HEAD_RIGHT = 2'd0,
        HEAD_DOWN  = 2'd1,
        HEAD_LEFT  = 2'd2,
        HEAD_UP    = 2'd3
    } heading_t;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,                        // Snake held at start, waits for a button
        ST_WAIT  = 3'd1,                        // Waits for game_tik
        ST_STEP  = 3'd2,                        // Head moves
        ST_CHECK = 3'd3,                        // Looks for the fruit under the head
        ST_EAT   = 3'd4,                        // Grow, score and first fruit candidate
        ST_PLACE = 3'd5,                        // Retries until the fruit is free
        ST_OVER  = 3'd6                         // Wall or body hit
    } game_state_t;

    // Status seen at the top level
    typedef struct packed {
        game_state_t state;
        heading_t    heading;
    } game_status_t;

    // One-cycle enables from the FSM to the datapath blocks
    typedef struct packed {
        logic init;                             // Reload start values
        logic step;                             // Move the head one cell
        logic grow;                             // Length, score and new fruit
    } move_ctrl_t;

endpackage

// ==== hw/turn_input.sv ====
// Button synchronizers, rising edge detect, pending turn latch and heading register
`timescale 1ns/1ns

module turn_input (
    input  logic                clock_25,
    input  logic                reset,
    input  logic                turn_right,     // Raw button, clockwise
    input  logic                turn_left,      // Raw button, counter-clockwise
    input  logic                init,
    input  logic                step,
    output snake_pkg::heading_t heading,        // Heading used by the move logic
    output logic                start_press     // Any button edge
);

    logic [2:0]          right_sync;            // Two sync flops plus one for edge detect
    logic [2:0]          left_sync;
    logic                right_edge;
    logic                left_edge;
    logic                pend_cw;               // Turn waiting for the next step
    logic                pend_ccw;
    snake_pkg::heading_t heading_q;
    snake_pkg::heading_t heading_turned;        // Heading with the pending turn applied

    // Bit 0 and 1 synchronize, bit 2 holds the previous synchronized level
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_sync <= '0;
            left_sync  <= '0;
        end else begin
            right_sync <= {right_sync[1:0], turn_right};
            left_sync  <= {left_sync[1:0], turn_left};
        end
    end

    assign right_edge  = right_sync[1] & ~right_sync[2];  // High for one cycle per press
    assign left_edge   = left_sync[1] & ~left_sync[2];
    assign start_press = right_edge | left_edge;

    // Latest press wins, both at once cancel
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            pend_cw  <= 1'b0;
            pend_ccw <= 1'b0;
        end else if (init) begin                // Start press never turns the snake
            pend_cw  <= 1'b0;
            pend_ccw <= 1'b0;
        end else if (right_edge || left_edge) begin
            pend_cw  <= right_edge & ~left_edge;
            pend_ccw <= left_edge & ~right_edge;
        end else if (step) begin                // Turn consumed by this move
            pend_cw  <= 1'b0;
            pend_ccw <= 1'b0;
        end
    end

    // Rotate by one quarter in the clockwise enum order
    always_comb begin
        heading_turned = heading_q;
        if (pend_cw)
            heading_turned = snake_pkg::heading_t'(heading_q + 2'd1);
        else if (pend_ccw)
            heading_turned = snake_pkg::heading_t'(heading_q - 2'd1);
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            heading_q <= snake_pkg::HEAD_RIGHT;  // Game always starts moving right
        else if (init)
            heading_q <= snake_pkg::HEAD_RIGHT;
        else if (step)
            heading_q <= heading_turned;        // Commit the turn with the move
    end

    // During step the move already sees the turned heading
    assign heading = step ? heading_turned : heading_q;

endmodule

// ==== hw/game_control.sv ====
// Game FSM sequencing start, step, fruit check, eat, fruit placement and game over
`timescale 1ns/1ns

module game_control (
    input  logic                   clock_25,
    input  logic                   reset,
    input  logic                   game_tik,     // One-cycle move tick
    input  logic                   start_press,  // Button edge from turn_input
    input  logic                   hit_next,     // Next move would collide
    input  logic                   fruit_eaten,  // Head on the fruit
    input  logic                   fruit_valid,  // Fruit inside grid and off the snake
    output snake_pkg::move_ctrl_t  move_ctrl,
    output snake_pkg::game_state_t state
);

    snake_pkg::game_state_t state_q;
    snake_pkg::game_state_t state_d;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            state_q <= snake_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    // Next state
    always_comb begin
        state_d = state_q;                      // Hold by default
        case (state_q)
            snake_pkg::ST_IDLE: begin
                if (start_press)
                    state_d = snake_pkg::ST_WAIT;
            end
            snake_pkg::ST_WAIT: begin
                if (game_tik)                   // Ticks elsewhere are dropped
                    state_d = snake_pkg::ST_STEP;
            end
            snake_pkg::ST_STEP: begin
                if (hit_next)
                    state_d = snake_pkg::ST_OVER;  // Head stays put
                else
                    state_d = snake_pkg::ST_CHECK;
            end
            snake_pkg::ST_CHECK: begin
                if (fruit_eaten)
                    state_d = snake_pkg::ST_EAT;
                else
                    state_d = snake_pkg::ST_WAIT;
            end
            snake_pkg::ST_EAT: begin
                state_d = snake_pkg::ST_PLACE;  // First candidate loaded here
            end
            snake_pkg::ST_PLACE: begin
                if (fruit_valid)
                    state_d = snake_pkg::ST_WAIT;  // One retry per cycle until then
            end
            snake_pkg::ST_OVER: begin
                if (start_press)
                    state_d = snake_pkg::ST_IDLE;
            end
            default: state_d = snake_pkg::ST_IDLE;  // Unused encoding
        endcase
    end

    // Moore enables, decoded from the state register only
    always_comb begin
        move_ctrl = '0;
        case (state_q)
            snake_pkg::ST_IDLE: move_ctrl.init = 1'b1;  // Keep the board at start
            snake_pkg::ST_OVER: move_ctrl.init = 1'b1;
            snake_pkg::ST_STEP: move_ctrl.step = 1'b1;
            snake_pkg::ST_EAT:  move_ctrl.grow = 1'b1;
            default:            move_ctrl = '0;
        endcase
    end

    assign state = state_q;

endmodule

// ==== hw/snake_body.sv ====
// Head and body registers, next head, wall and self collision, snake length
`timescale 1ns/1ns
`include "snake_params.svh"

module snake_body (
    input  logic                        clock_25,
    input  logic                        reset,
    input  snake_pkg::move_ctrl_t       move_ctrl,
    input  snake_pkg::heading_t         heading,
    output snake_pkg::cell_t            head,
    output snake_pkg::cell_t            body [`SNAKE_LEN_MAX-1],  // Slot 0 is next to the head
    output logic [`SNAKE_LEN_BITS-1:0]  length,                   // Head included
    output logic                        hit_next
);

    localparam int CW         = `SNAKE_COORD_BITS;
    localparam int LB         = `SNAKE_LEN_BITS;
    localparam int BODY_SLOTS = `SNAKE_LEN_MAX - 1;

    localparam logic [CW-1:0] X_LAST = CW'(`SNAKE_GRID_W - 1);   // Rightmost column
    localparam logic [CW-1:0] Y_LAST = CW'(`SNAKE_GRID_H - 1);   // Bottom row
    localparam logic [LB-1:0] LEN_FULL  = LB'(`SNAKE_LEN_MAX);
    localparam logic [LB-1:0] LEN_START = LB'(`SNAKE_START_LEN);
    localparam snake_pkg::cell_t START_HEAD = '{x: CW'(`SNAKE_START_X), y: CW'(`SNAKE_START_Y)};

    snake_pkg::cell_t next_head;
    logic             hit_wall;
    logic             hit_self;
    logic             do_move;

    // Candidate head one cell along the heading
    always_comb begin
        next_head = head;
        hit_wall  = 1'b0;
        case (heading)
            snake_pkg::HEAD_RIGHT: begin
                next_head.x = head.x + 1'b1;
                hit_wall    = (head.x == X_LAST);
            end
            snake_pkg::HEAD_DOWN: begin
                next_head.y = head.y + 1'b1;    // Rows count downwards
                hit_wall    = (head.y == Y_LAST);
            end
            snake_pkg::HEAD_LEFT: begin
                next_head.x = head.x - 1'b1;
                hit_wall    = (head.x == '0);
            end
            default: begin                      // Up
                next_head.y = head.y - 1'b1;
                hit_wall    = (head.y == '0);
            end
        endcase
    end

    // Only the length-1 active slots count as body
    always_comb begin
        hit_self = 1'b0;
        for (int i = 0; i < BODY_SLOTS; i++) begin
            if ((i < int'(length) - 1) && (body[i] == next_head))
                hit_self = 1'b1;
        end
    end

    assign hit_next = hit_wall | hit_self;
    assign do_move  = move_ctrl.step & ~hit_next;  // Blocked move leaves the snake frozen

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head   <= START_HEAD;
            length <= LEN_START;
        end else if (move_ctrl.init) begin
            head   <= START_HEAD;
            length <= LEN_START;
        end else begin
            if (do_move)
                head <= next_head;
            if (move_ctrl.grow && (length != LEN_FULL))  // Saturate at 16
                length <= length + 1'b1;
        end
    end

    // Body shift register, the old tail stays behind for growth
    always_ff @(posedge clock_25) begin
        if (move_ctrl.init) begin
            for (int i = 0; i < BODY_SLOTS; i++) begin
                if (i < `SNAKE_START_LEN - 1)
                    body[i] <= '{x: CW'(`SNAKE_START_X - 1 - i), y: CW'(`SNAKE_START_Y)};
                else
                    body[i] <= '1;              // Off-grid marker
            end
        end else if (do_move) begin
            body[0] <= head;
            for (int i = 1; i < BODY_SLOTS; i++)
                body[i] <= body[i-1];
        end
    end

endmodule

// ==== hw/fruit_placer.sv ====
// Fruit LFSRs, fruit register with retry, fruit validity and eaten checks, score
`timescale 1ns/1ns
`include "snake_params.svh"

module fruit_placer (
    input  logic                        clock_25,
    input  logic                        reset,
    input  snake_pkg::move_ctrl_t       move_ctrl,
    input  snake_pkg::cell_t            head,
    input  snake_pkg::cell_t            body [`SNAKE_LEN_MAX-1],
    input  logic [`SNAKE_LEN_BITS-1:0]  length,
    output snake_pkg::cell_t            fruit,
    output logic [6:0]                  score,        // 0..99
    output logic                        fruit_eaten,
    output logic                        fruit_valid
);

    localparam int CW = `SNAKE_COORD_BITS;
    localparam logic [CW-1:0] TAPS_X = 7'h41;       // x^7 + x^6 + 1
    localparam logic [CW-1:0] TAPS_Y = 7'h09;       // x^7 + x^3 + 1
    localparam logic [6:0]    SCORE_LAST = 7'(`SNAKE_SCORE_WRAP);
    localparam snake_pkg::cell_t START_FRUIT = '{x: CW'(`SNAKE_FRUIT_X), y: CW'(`SNAKE_FRUIT_Y)};

    logic [CW-1:0]    lfsr_x;
    logic [CW-1:0]    lfsr_y;
    snake_pkg::cell_t candidate;
    logic             placing;                      // Between grow and a valid fruit
    logic             on_snake;

    // Galois step, maximal length so zero is never reached
    function automatic logic [CW-1:0] lfsr_next(input logic [CW-1:0] s,
                                                 input logic [CW-1:0] taps);
        lfsr_next = {s[CW-2:0], 1'b0} ^ (s[CW-1] ? taps : '0);
    endfunction

    // Free running, the sample time gives the randomness
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= `SNAKE_LFSR_SEED_X;
            lfsr_y <= `SNAKE_LFSR_SEED_Y;
        end else begin
            lfsr_x <= lfsr_next(lfsr_x, TAPS_X);
            lfsr_y <= lfsr_next(lfsr_y, TAPS_Y);
        end
    end

    assign candidate = '{x: lfsr_x, y: lfsr_y};

    // Fruit must sit inside the grid and on no active snake cell
    always_comb begin
        on_snake = (fruit == head);
        for (int i = 0; i < `SNAKE_LEN_MAX - 1; i++) begin
            if ((i < int'(length) - 1) && (body[i] == fruit))
                on_snake = 1'b1;
        end
        fruit_valid = (fruit.x < CW'(`SNAKE_GRID_W)) && (fruit.y < CW'(`SNAKE_GRID_H))
                      && !on_snake;
    end

    assign fruit_eaten = (fruit == head);

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit   <= START_FRUIT;
            score   <= '0;
            placing <= 1'b0;
        end else if (move_ctrl.init) begin
            fruit   <= START_FRUIT;
            score   <= '0;
            placing <= 1'b0;
        end else if (move_ctrl.grow) begin
            fruit   <= candidate;                   // First try
            score   <= (score == SCORE_LAST) ? 7'd0 : score + 7'd1;
            placing <= 1'b1;
        end else if (placing) begin
            if (fruit_valid)
                placing <= 1'b0;                    // FSM leaves place this cycle
            else
                fruit <= candidate;                 // Retry with the next draw
        end
    end

endmodule

// ==== hw/snake_game_top.sv ====
// Snake game top level connecting input, control, body and fruit blocks
`timescale 1ns/1ns
`include "snake_params.svh"

module snake_game_top (
    input  logic                        clock_25,
    input  logic                        reset,
    input  logic                        game_tik,
    input  logic                        turn_right,
    input  logic                        turn_left,
    output snake_pkg::cell_t            head,
    output snake_pkg::cell_t            fruit,
    output logic [`SNAKE_LEN_BITS-1:0]  length,
    output logic [6:0]                  score,
    output snake_pkg::game_status_t     status
);

    snake_pkg::move_ctrl_t  move_ctrl;      // Enables from the FSM
    snake_pkg::heading_t    heading;
    snake_pkg::game_state_t state;
    snake_pkg::cell_t       body [`SNAKE_LEN_MAX-1];
    logic                   start_press;
    logic                   hit_next;
    logic                   fruit_eaten;
    logic                   fruit_valid;

    turn_input u_turn_input (
        .clock_25    (clock_25),
        .reset       (reset),
        .turn_right  (turn_right),
        .turn_left   (turn_left),
        .init        (move_ctrl.init),
        .step        (move_ctrl.step),
        .heading     (heading),
        .start_press (start_press)
    );

    game_control u_game_control (
        .clock_25    (clock_25),
        .reset       (reset),
        .game_tik    (game_tik),
        .start_press (start_press),
        .hit_next    (hit_next),
        .fruit_eaten (fruit_eaten),
        .fruit_valid (fruit_valid),
        .move_ctrl   (move_ctrl),
        .state       (state)
    );

    snake_body u_snake_body (
        .clock_25  (clock_25),
        .reset     (reset),
        .move_ctrl (move_ctrl),
        .heading   (heading),
        .head      (head),
        .body      (body),
        .length    (length),
        .hit_next  (hit_next)
    );

    fruit_placer u_fruit_placer (
        .clock_25    (clock_25),
        .reset       (reset),
        .move_ctrl   (move_ctrl),
        .head        (head),
        .body        (body),
        .length      (length),
        .fruit       (fruit),
        .score       (score),
        .fruit_eaten (fruit_eaten),
        .fruit_valid (fruit_valid)
    );

    assign status = '{state: state, heading: heading};  // Heading is the one the move uses

endmodule

// ==== verification/tb_snake_game.sv ====
// Snake game testbench with clock, reset, LCG gaps, stimulus tasks, snake model, checks and watchdog
`timescale 1ns/1ns
`include "snake_params.svh"

module tb_snake_game;

    localparam int TOTAL_TICKS     = 3 + 3 + 3 + `SNAKE_GRID_W + 2 + 3;  // Ticks over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_TICKS * 20 + 2000;
    localparam int SETTLE_LIMIT    = 300;          // Tick to wait or over, placement included

    logic                       clock_25   = 1'b0;
    logic                       reset      = 1'b0;    // Active low, held from time 0
    logic                       game_tik   = 1'b0;
    logic                       turn_right = 1'b0;
    logic                       turn_left  = 1'b0;
    snake_pkg::cell_t           head;
    snake_pkg::cell_t           fruit;
    logic [`SNAKE_LEN_BITS-1:0] length;
    logic [6:0]                 score;
    snake_pkg::game_status_t    status;

    // Reference snake
    int                     m_hx;                      // Head
    int                     m_hy;
    int                     m_fx;                      // Fruit
    int                     m_fy;
    int                     m_bx [`SNAKE_LEN_MAX-1];   // Body, slot 0 behind the head
    int                     m_by [`SNAKE_LEN_MAX-1];
    int                     m_len;
    int                     m_score;
    int                     m_heading;                 // 0 right, 1 down, 2 left, 3 up
    int                     m_pend;                    // Quarter turns waiting for a step
    snake_pkg::game_state_t m_state;

    int unsigned lcg_state       = 32'h5196_b8ad;
    int          error_count     = 0;
    int          prop_fail_count = 0;
    int          errors_at_start = 0;
    int          tests_passed    = 0;
    int          tests_failed    = 0;

    snake_game_top u_snake_game_top (
        .clock_25   (clock_25),
        .reset      (reset),
        .game_tik   (game_tik),
        .turn_right (turn_right),
        .turn_left  (turn_left),
        .head       (head),
        .fruit      (fruit),
        .length     (length),
        .score      (score),
        .status     (status)
    );

    always #10 clock_25 = ~clock_25;               // 20 ns period

    // A waiting FSM always has a fruit on the board
    fruit_on_board: assert property (@(posedge clock_25) disable iff (!reset)
        (status.state == snake_pkg::ST_WAIT) |->
            ((fruit.x < 7'(`SNAKE_GRID_W)) && (fruit.y < 7'(`SNAKE_GRID_H))))
        else begin
            prop_fail_count++;
            $display("Fruit (%0d,%0d) lies outside the grid at %0t", fruit.x, fruit.y, $time);
        end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            error_count++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // Start board, as loaded by init in idle and over
    task automatic model_init();
        m_hx      = `SNAKE_START_X;
        m_hy      = `SNAKE_START_Y;
        m_fx      = `SNAKE_FRUIT_X;
        m_fy      = `SNAKE_FRUIT_Y;
        m_len     = `SNAKE_START_LEN;
        m_score   = 0;
        m_heading = 0;
        m_pend    = 0;
        for (int i = 0; i < `SNAKE_LEN_MAX - 1; i++) begin
            m_bx[i] = (i < `SNAKE_START_LEN - 1) ? `SNAKE_START_X - 1 - i : 127;  // All ones
            m_by[i] = (i < `SNAKE_START_LEN - 1) ? `SNAKE_START_Y : 127;
        end
    endtask

    task automatic check_outputs();
        check_value("head.x", int'(head.x), m_hx);
        check_value("head.y", int'(head.y), m_hy);
        check_value("fruit.x", int'(fruit.x), m_fx);
        check_value("fruit.y", int'(fruit.y), m_fy);
        check_value("length", int'(length), m_len);
        check_value("score", int'(score), m_score);
        check_value("status.heading", int'(status.heading), m_heading);
        check_value("status.state", int'(status.state), int'(m_state));
    endtask

    task automatic random_gap();
        repeat (next_random() >> 29) @(posedge clock_25);  // 0 to 7 idle cycles
    endtask

    task automatic send_tick();
        @(posedge clock_25);
        game_tik <= 1'b1;
        @(posedge clock_25);
        game_tik <= 1'b0;
    endtask

    task automatic press(input logic right, input logic left);
        @(posedge clock_25);
        turn_right <= right;
        turn_left  <= left;
        @(posedge clock_25);
        turn_right <= 1'b0;
        turn_left  <= 1'b0;
        repeat (3) @(posedge clock_25);            // Sync flops plus edge detect
        if (m_state == snake_pkg::ST_IDLE)
            m_state = snake_pkg::ST_WAIT;          // Start, init keeps the heading
        else if (m_state == snake_pkg::ST_OVER)
            m_state = snake_pkg::ST_IDLE;
        else
            m_pend = (right && !left) ? 1 : ((left && !right) ? 3 : 0);  // Both cancel
        @(negedge clock_25);
        check_outputs();
    endtask

    // New fruit must be inside the grid and off the model snake
    task automatic check_fruit_free();
        bit on_snake;
        on_snake = (int'(fruit.x) == m_hx) && (int'(fruit.y) == m_hy);
        for (int i = 0; i < m_len - 1; i++)
            on_snake |= (int'(fruit.x) == m_bx[i]) && (int'(fruit.y) == m_by[i]);
        assert (!on_snake && int'(fruit.x) < `SNAKE_GRID_W && int'(fruit.y) < `SNAKE_GRID_H)
        else begin
            error_count++;
            $display("New fruit at (%0d,%0d) is off the grid or on the snake", fruit.x, fruit.y);
        end
        m_fx = int'(fruit.x);                      // Random cell, tracked from here on
        m_fy = int'(fruit.y);
    endtask

    task automatic tick_and_check();
        int nx;
        int ny;
        int cycles;
        bit hit;
        m_heading = (m_heading + m_pend) % 4;     // Turn applies to this move
        m_pend    = 0;
        nx  = m_hx + ((m_heading == 0) ? 1 : ((m_heading == 2) ? -1 : 0));
        ny  = m_hy + ((m_heading == 1) ? 1 : ((m_heading == 3) ? -1 : 0));
        hit = (nx < 0) || (nx >= `SNAKE_GRID_W) || (ny < 0) || (ny >= `SNAKE_GRID_H);
        for (int i = 0; i < m_len - 1; i++)
            hit |= (m_bx[i] == nx) && (m_by[i] == ny);
        random_gap();
        send_tick();
        cycles = 0;
        do begin
            @(negedge clock_25);
            cycles++;
        end while (status.state != snake_pkg::ST_WAIT && status.state != snake_pkg::ST_OVER
                   && cycles < SETTLE_LIMIT);
        if (cycles >= SETTLE_LIMIT) begin
            error_count++;
            $display("FSM stuck for %0d cycles after a tick at %0t", cycles, $time);
        end
        if (hit) begin
            m_state = snake_pkg::ST_OVER;          // Head frozen on the entry cycle
            check_outputs();
            model_init();                          // Init runs while in over
        end else begin
            for (int i = `SNAKE_LEN_MAX - 2; i > 0; i--) begin
                m_bx[i] = m_bx[i-1];
                m_by[i] = m_by[i-1];
            end
            m_bx[0] = m_hx;
            m_by[0] = m_hy;
            m_hx    = nx;
            m_hy    = ny;
            if (m_hx == m_fx && m_hy == m_fy) begin
                m_score = (m_score == `SNAKE_SCORE_WRAP) ? 0 : m_score + 1;
                m_len   = (m_len < `SNAKE_LEN_MAX) ? m_len + 1 : m_len;
                check_fruit_free();
            end else begin
                assert (cycles <= 3) else begin
                    error_count++;
                    $display("Plain move took %0d cycles to reach wait at %0t", cycles, $time);
                end
            end
            check_outputs();
        end
    endtask

    task automatic end_test(input string name);
        if (error_count + prop_fail_count == errors_at_start) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s", name);
        end
        errors_at_start = error_count + prop_fail_count;
    endtask

    initial begin
        model_init();
        m_state = snake_pkg::ST_IDLE;
        repeat (3) @(posedge clock_25);
        reset <= 1'b1;
        @(negedge clock_25);
        check_outputs();
        repeat (3) begin                           // Ticks are lost in idle
            send_tick();
            random_gap();
        end
        @(negedge clock_25);
        check_outputs();
        end_test("idle after reset");

        press(1'b1, 1'b0);                         // Start only, no turn
        repeat (3) tick_and_check();
        end_test("start and straight moves");

        press(1'b1, 1'b0);
        tick_and_check();
        check_value("status.heading", int'(status.heading), int'(snake_pkg::HEAD_DOWN));
        press(1'b0, 1'b1);
        tick_and_check();
        check_value("status.heading", int'(status.heading), int'(snake_pkg::HEAD_RIGHT));
        press(1'b1, 1'b1);
        tick_and_check();
        check_value("status.heading", int'(status.heading), int'(snake_pkg::HEAD_RIGHT));
        end_test("turns");

        while (m_state == snake_pkg::ST_WAIT && m_hx < `SNAKE_GRID_W - 1)
            tick_and_check();
        tick_and_check();                          // Into the right wall
        check_value("head.x", int'(head.x), `SNAKE_GRID_W - 1);
        check_value("status.state", int'(status.state), int'(snake_pkg::ST_OVER));
        press(1'b0, 1'b1);
        check_value("status.state", int'(status.state), int'(snake_pkg::ST_IDLE));
        end_test("wall collision and restart");

        press(1'b0, 1'b1);
        press(1'b1, 1'b0);                         // Head down towards the start fruit
        repeat (2) tick_and_check();
        check_value("head.y", int'(head.y), `SNAKE_FRUIT_Y);
        check_value("score", int'(score), 1);
        check_value("length", int'(length), `SNAKE_START_LEN + 1);
        end_test("fruit eaten");

        repeat (3) begin                           // Curl back into the body
            press(1'b1, 1'b0);
            tick_and_check();
        end
        check_value("status.state", int'(status.state), int'(snake_pkg::ST_OVER));
        end_test("self collision");

        $display("Tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count + prop_fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_25);
        $display("Watchdog expired after %0d cycles, test sequence stalled", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/snake_pkg.sv
hw/turn_input.sv
hw/game_control.sv
hw/snake_body.sv
hw/fruit_placer.sv
hw/snake_game_top.sv
verification/tb_snake_game.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snake game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_snake_game -o tb_snake_game
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_snake_game)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation completed successfully$'; then
    exit 0
fi
exit 1
